//--- hdl/slime_pkg.sv
package slime_pkg;

    typedef logic [9:0] coord_t;     // screen coordinate on the 640x480 raster
    typedef logic [8:0] phase_cnt_t;
    typedef logic [3:0] digit_t;     // one decimal digit of the score

    typedef enum logic [1:0] {
        HEAD_IDLE,
        HEAD_LEFT,
        HEAD_RIGHT
    } heading_t;

    typedef enum logic {
        PHASE_RISE,
        PHASE_FALL
    } phase_t;

    // slime geometry
    localparam coord_t X_START = 10'd310;
    localparam coord_t Y_START = 10'd379;
    localparam coord_t X_MAX = 10'd619;     // last column the slime's left edge may take
    localparam coord_t Y_BOTTOM = 10'd479;
    localparam coord_t Y_CEILING = 10'd240; // bounces above this row score a point
    localparam coord_t SLIME_W = 10'd20;
    localparam coord_t PLATFORM_W = 10'd40;

    // the rise and the fall each run through four speed bands of equal length
    localparam phase_cnt_t BAND_LEN = 9'd80;
    localparam phase_cnt_t PHASE_END = 9'd320;

    localparam digit_t TENS_LIMIT = 4'd10;

endpackage

//--- hdl/slime_horizontal.sv
`timescale 1ns/1ps

module slime_horizontal import slime_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       tick_x,
    input  logic [1:0] key,
    output coord_t     x
);

    heading_t heading;

    // the heading follows the keys on every edge while ticks only pace the motion
    always_ff @(posedge clk) begin
        if (rst) begin
            heading <= HEAD_IDLE;
        end else begin
            case (key)
                2'b10:   heading <= HEAD_LEFT;
                2'b01:   heading <= HEAD_RIGHT;
                default: heading <= heading; // no key or both keys keep the last heading
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            x <= X_START;
        end else if (tick_x) begin
            case (heading)
                HEAD_LEFT: begin
                    if (x == '0)
                        x <= X_MAX; // wrap to the right edge
                    else
                        x <= x - 10'd1;
                end
                HEAD_RIGHT: begin
                    if (x >= X_MAX)
                        x <= '0;
                    else
                        x <= x + 10'd1;
                end
                default: x <= x;
            endcase
        end
    end

endmodule

//--- hdl/platform_detect.sv
`timescale 1ns/1ps

module platform_detect import slime_pkg::*; #(
    parameter int NUM_PLATFORMS = 8
) (
    input  coord_t                     x,
    input  coord_t                     y,
    input  coord_t [NUM_PLATFORMS-1:0] platform_x,
    input  coord_t [NUM_PLATFORMS-1:0] platform_y,
    input  logic   [NUM_PLATFORMS-1:0] platform_enable,
    output logic                       landed
);

    coord_t                     x_right;
    logic   [NUM_PLATFORMS-1:0] on_top;

    assign x_right = x + SLIME_W;

    always_comb begin
        coord_t left_edge;
        coord_t right_edge;
        coord_t top_row;
        for (int i = 0; i < NUM_PLATFORMS; i++) begin
            left_edge = platform_x[i];
            right_edge = platform_x[i] + PLATFORM_W;
            top_row = platform_y[i] - 10'd1; // the slime rests one row above the platform
            // either foot of the slime may carry it
            on_top[i] = platform_enable[i] && (y == top_row) &&
                        ((x >= left_edge && x <= right_edge) ||
                         (x_right >= left_edge && x_right <= right_edge));
        end
    end

    assign landed = |on_top;

endmodule

//--- hdl/jump_physics.sv
`timescale 1ns/1ps

module jump_physics import slime_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   tick_y,
    input  logic   landed,
    output coord_t y,
    output logic   hit_ceiling,
    output logic   score_event,
    output logic   floor_hit
);

    phase_t     phase;
    phase_t     phase_next;
    phase_cnt_t cnt;
    phase_cnt_t cnt_next;
    coord_t     y_next;
    logic       hit_ceiling_next;
    logic       bounce;
    logic [1:0] band;
    logic       in_band;
    logic [1:0] rate;
    logic       step_due;

    // band 0 covers counter values 1 to 79 and band 3 ends at 319 while 320 moves nothing
    always_comb begin
        in_band = 1'b1;
        if (cnt < BAND_LEN) begin
            band = 2'd0;
        end else if (cnt < phase_cnt_t'(2 * BAND_LEN)) begin
            band = 2'd1;
        end else if (cnt < phase_cnt_t'(3 * BAND_LEN)) begin
            band = 2'd2;
        end else if (cnt < PHASE_END) begin
            band = 2'd3;
        end else begin
            band = 2'd3;
            in_band = 1'b0;
        end
    end

    // a rise starts fast and slows down while a fall mirrors it
    assign rate = (phase == PHASE_FALL) ? 2'd3 - band : band;

    always_comb begin
        case (rate)
            2'd0:    step_due = in_band;
            2'd1:    step_due = in_band && (cnt[0] == 1'b0);
            2'd2:    step_due = in_band && (cnt[1:0] == 2'b00);
            default: step_due = in_band && (cnt[2:0] == 3'b000);
        endcase
    end

    assign floor_hit = (phase == PHASE_FALL) && (y == Y_BOTTOM);
    assign bounce = (phase == PHASE_FALL) && (y != Y_BOTTOM) && landed;
    assign score_event = bounce && (y < Y_CEILING);

    always_comb begin
        phase_next = phase;
        cnt_next = cnt;
        y_next = y;
        hit_ceiling_next = hit_ceiling;
        case (phase)
            PHASE_RISE: begin
                if (cnt > PHASE_END) begin
                    phase_next = PHASE_FALL;
                    cnt_next = 9'd1;
                    hit_ceiling_next = 1'b0;
                end else begin
                    cnt_next = cnt + 9'd1;
                    // above the ceiling the screen scrolls instead, so y stays put
                    if (!hit_ceiling && step_due)
                        y_next = y - 10'd1;
                end
            end
            default: begin
                if (floor_hit) begin
                    cnt_next = 9'd1;
                end else if (bounce) begin
                    phase_next = PHASE_RISE;
                    cnt_next = 9'd1;
                    hit_ceiling_next = (y < Y_CEILING);
                end else if (cnt > PHASE_END) begin
                    y_next = y + 10'd1; // at terminal speed the counter stays where it is
                end else begin
                    cnt_next = cnt + 9'd1;
                    if (step_due)
                        y_next = y + 10'd1;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= PHASE_FALL;
            cnt <= 9'd1;
            y <= Y_START;
            hit_ceiling <= 1'b0;
        end else if (tick_y) begin
            phase <= phase_next;
            cnt <= cnt_next;
            y <= y_next;
            hit_ceiling <= hit_ceiling_next;
        end
    end

endmodule

//--- hdl/score_keeper.sv
`timescale 1ns/1ps

module score_keeper import slime_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   tick_y,
    input  logic   score_event,
    input  logic   floor_hit,
    output digit_t score_ones,
    output digit_t score_tens,
    output logic   slime_die
);

    // decimal counter that adds one point for every bounce made above the ceiling line
    always_ff @(posedge clk) begin
        if (rst) begin
            score_ones <= '0;
            score_tens <= '0;
        end else if (tick_y && score_event) begin
            if (score_ones == 4'd9) begin
                score_ones <= '0;
                score_tens <= score_tens + 4'd1;
            end else begin
                score_ones <= score_ones + 4'd1;
            end
        end
    end

    // the game ends at a hundred points or when the slime drops off the bottom
    assign slime_die = (score_tens == TENS_LIMIT) || floor_hit;

endmodule

//--- hdl/slime_top.sv
`timescale 1ns/1ps

module slime_top import slime_pkg::*; #(
    parameter int NUM_PLATFORMS = 8
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       tick_y,
    input  logic                       tick_x,
    input  logic   [1:0]               key,
    input  coord_t [NUM_PLATFORMS-1:0] platform_x,
    input  coord_t [NUM_PLATFORMS-1:0] platform_y,
    input  logic   [NUM_PLATFORMS-1:0] platform_enable,
    output coord_t                     x,
    output coord_t                     y,
    output logic                       hit_ceiling,
    output digit_t                     score_ones,
    output digit_t                     score_tens,
    output logic                       slime_die
);

    logic landed;
    logic score_event;
    logic floor_hit;

    slime_horizontal u_horizontal (
        .clk    (clk),
        .rst    (rst),
        .tick_x (tick_x),
        .key    (key),
        .x      (x)
    );

    platform_detect #(
        .NUM_PLATFORMS (NUM_PLATFORMS)
    ) u_platform_detect (
        .x               (x),
        .y               (y),
        .platform_x      (platform_x),
        .platform_y      (platform_y),
        .platform_enable (platform_enable),
        .landed          (landed)
    );

    jump_physics u_jump_physics (
        .clk         (clk),
        .rst         (rst),
        .tick_y      (tick_y),
        .landed      (landed),
        .y           (y),
        .hit_ceiling (hit_ceiling),
        .score_event (score_event),
        .floor_hit   (floor_hit)
    );

    score_keeper u_score_keeper (
        .clk         (clk),
        .rst         (rst),
        .tick_y      (tick_y),
        .score_event (score_event),
        .floor_hit   (floor_hit),
        .score_ones  (score_ones),
        .score_tens  (score_tens),
        .slime_die   (slime_die)
    );

endmodule

//--- bench/slime_tb.sv
`timescale 1ns/1ps

module slime_tb import slime_pkg::*; ();

    localparam int NUM_PLATFORMS = 8;
    localparam int CLK_PERIOD = 100;
    localparam int STEER_LIMIT = 400;
    localparam int FALL_LIMIT = 400;
    localparam int RISE_LIMIT = 500;
    localparam int BOUNCE_LIMIT = 500;
    localparam int BOUNCES_TO_DIE = 100;
    // an unfrozen rise steps every tick, then every 2nd, 4th and 8th tick of a band
    localparam int RISE_HEIGHT = (BAND_LEN - 1) + BAND_LEN / 2 + BAND_LEN / 4 + BAND_LEN / 8;
    localparam int WORST_CYCLES = STEER_LIMIT + 3 * FALL_LIMIT + RISE_LIMIT +
                                  BOUNCES_TO_DIE * BOUNCE_LIMIT + 100;

    logic                       clk;
    logic                       rst;
    logic                       tick_y;
    logic                       tick_x;
    logic [1:0]                 key;
    coord_t [NUM_PLATFORMS-1:0] platform_x;
    coord_t [NUM_PLATFORMS-1:0] platform_y;
    logic   [NUM_PLATFORMS-1:0] platform_enable;
    coord_t                     x;
    coord_t                     y;
    logic                       hit_ceiling;
    digit_t                     score_ones;
    digit_t                     score_tens;
    logic                       slime_die;

    integer seed = 32'h161fc399;
    int     check_count = 0;
    int     error_count = 0;
    int     tests_passed = 0;
    int     tests_failed = 0;
    int     test_mark = 0;

    heading_t exp_head;
    coord_t   exp_x;
    logic     model_valid = 1'b0;
    coord_t   last_x;
    coord_t   last_y;
    logic     last_hit_ceiling = 1'b0;
    bit       left_wrap_seen;
    bit       right_wrap_seen;

    slime_top #(
        .NUM_PLATFORMS (NUM_PLATFORMS)
    ) DUT (
        .clk             (clk),
        .rst             (rst),
        .tick_y          (tick_y),
        .tick_x          (tick_x),
        .key             (key),
        .platform_x      (platform_x),
        .platform_y      (platform_y),
        .platform_enable (platform_enable),
        .x               (x),
        .y               (y),
        .hit_ceiling     (hit_ceiling),
        .score_ones      (score_ones),
        .score_tens      (score_tens),
        .slime_die       (slime_die)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            $display("mismatch at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_true(input bit ok, input string what);
        check_count++;
        assert (ok) else begin
            $display("error at %0t: %s", $time, what);
            error_count++;
        end
    endtask

    function automatic int score_value();
        return score_tens * 10 + score_ones;
    endfunction

    task automatic open_test;
        test_mark = error_count;
    endtask

    task automatic close_test(input string name);
        if (error_count == test_mark) begin
            tests_passed++;
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail, %0d errors", name, error_count - test_mark);
        end
    endtask

    // ends on the negedge after the last reset edge, with ticks and keys quiet
    task automatic apply_reset;
        @(posedge clk);
        rst <= 1'b1;
        tick_y <= 1'b0;
        tick_x <= 1'b0;
        key <= 2'b00;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
    endtask

    task automatic run_ticks_y;
        @(posedge clk);
        tick_y <= 1'b1;
        @(negedge clk);
    endtask

    task automatic fall_until(input coord_t target, input int limit);
        coord_t prev;
        bit     reached;
        reached = (y == target);
        for (int i = 0; i < limit && !reached; i++) begin
            prev = y;
            @(negedge clk);
            check_true(y >= prev, $sformatf("y went up from %0d to %0d while falling", prev, y));
            reached = (y == target);
        end
        check_true(reached, $sformatf("y did not reach %0d within %0d cycles", target, limit));
    endtask

    task automatic wait_score_change(input int limit, output bit changed);
        int start;
        start = score_value();
        changed = 1'b0;
        for (int i = 0; i < limit && !changed; i++) begin
            @(negedge clk);
            changed = (score_value() != start);
        end
        check_true(changed, $sformatf("score did not change within %0d cycles", limit));
    endtask

    // steering reference model in which a key reaches the heading one edge before it moves x
    always @(posedge clk) begin
        if (rst) begin
            model_valid <= 1'b1;
            exp_head <= HEAD_IDLE;
            exp_x <= X_START;
        end else begin
            if (key == 2'b10)
                exp_head <= HEAD_LEFT;
            else if (key == 2'b01)
                exp_head <= HEAD_RIGHT;
            if (tick_x && exp_head == HEAD_LEFT)
                exp_x <= (exp_x == '0) ? X_MAX : exp_x - 10'd1;
            else if (tick_x && exp_head == HEAD_RIGHT)
                exp_x <= (exp_x == X_MAX) ? '0 : exp_x + 10'd1;
        end
    end

    always @(negedge clk) begin
        if (model_valid && !rst) begin
            check_value("x", exp_x, x);
            if (last_x == '0 && x == X_MAX)
                left_wrap_seen = 1'b1;
            if (last_x == X_MAX && x == '0)
                right_wrap_seen = 1'b1;
            if (hit_ceiling && last_hit_ceiling)
                check_value("y", last_y, y); // the screen scrolls while the slime stays put
        end
        last_x = x;
        last_y = y;
        last_hit_ceiling = hit_ceiling;
    end

    initial begin
        coord_t lowest;
        coord_t prev;
        bit     turned;
        bit     ceiling_seen;
        bit     scored;
        int     r;
        int     side;

        rst = 1'b0;
        tick_y = 1'b0;
        tick_x = 1'b0;
        key = 2'b00;
        platform_x = '0;
        platform_y = '0;
        platform_enable = '0;

        open_test();
        apply_reset();
        check_value("x", X_START, x);
        check_value("y", Y_START, y);
        check_value("score_ones", 0, score_ones);
        check_value("score_tens", 0, score_tens);
        check_value("slime_die", 0, slime_die);
        check_value("hit_ceiling", 0, hit_ceiling);
        close_test("reset values");

        open_test();
        left_wrap_seen = 1'b0;
        right_wrap_seen = 1'b0;
        apply_reset();
        @(posedge clk);
        key <= 2'b10;
        tick_x <= 1'b1;
        repeat (320) @(posedge clk); // long enough to pass column 0
        key <= 2'b01;
        repeat (15) @(posedge clk);
        key <= 2'b00;
        repeat (5) @(posedge clk);
        tick_x <= 1'b0;
        key <= 2'b10;
        repeat (5) @(posedge clk);
        @(negedge clk);
        check_true(left_wrap_seen, "x never wrapped from 0 to the right edge");
        check_true(right_wrap_seen, "x never wrapped from the right edge to 0");
        close_test("steering");

        open_test();
        @(posedge clk);
        platform_enable <= '0;
        apply_reset();
        run_ticks_y();
        fall_until(Y_BOTTOM, FALL_LIMIT);
        repeat (10) begin
            @(negedge clk);
            check_value("y", Y_BOTTOM, y);
            check_value("slime_die", 1, slime_die);
        end
        check_value("score", 0, score_value());
        close_test("free fall");

        open_test();
        @(posedge clk);
        platform_x[0] <= X_START - 10'd10;
        platform_y[0] <= 10'd400;
        platform_enable <= 8'b0000_0001;
        apply_reset();
        run_ticks_y();
        fall_until(10'd399, FALL_LIMIT);
        lowest = y;
        turned = 1'b0;
        ceiling_seen = 1'b0;
        for (int i = 0; i < RISE_LIMIT && !turned; i++) begin
            prev = y;
            @(negedge clk);
            if (y < lowest)
                lowest = y;
            if (hit_ceiling)
                ceiling_seen = 1'b1;
            turned = (y > prev);
        end
        check_true(lowest < 10'd399, "y did not rise after landing on the platform");
        check_true(turned, "y never fell again after the rise");
        check_value("lowest y", 399 - RISE_HEIGHT, lowest);
        check_true(!ceiling_seen, "hit_ceiling rose on a bounce below the ceiling line");
        check_value("score", 0, score_value());
        close_test("landing and rise");

        open_test();
        r = $random(seed);
        side = $random(seed);
        @(posedge clk);
        // left of the slime or right of its right edge so that neither foot touches it
        if (side[0])
            platform_x[1] <= 10'(X_START + SLIME_W + 1 + ($unsigned(r) % 260));
        else
            platform_x[1] <= 10'($unsigned(r) % (X_START - PLATFORM_W));
        platform_y[1] <= 10'd400;
        platform_enable <= 8'b0000_0010;
        apply_reset();
        run_ticks_y();
        fall_until(Y_BOTTOM, FALL_LIMIT);
        check_value("slime_die", 1, slime_die);
        check_value("score", 0, score_value());
        close_test("no overlap");

        open_test();
        @(posedge clk);
        platform_x[0] <= X_START - 10'd10;
        platform_y[0] <= Y_START + 10'd1;   // bounce from the start row
        platform_x[2] <= X_START - 10'd10;
        platform_y[2] <= Y_CEILING - 10'd4; // just under the peak of the first rise
        platform_enable <= 8'b0000_0101;
        apply_reset();
        run_ticks_y();
        for (int k = 1; k <= BOUNCES_TO_DIE; k++) begin
            wait_score_change(BOUNCE_LIMIT, scored);
            if (!scored)
                break;
            check_value("score", k, score_value());
            check_value("hit_ceiling", 1, hit_ceiling);
            check_value("slime_die", k == BOUNCES_TO_DIE, slime_die);
            if (k == 10) begin
                check_value("score_ones", 0, score_ones);
                check_value("score_tens", 1, score_tens);
            end
        end
        check_value("score_tens", TENS_LIMIT, score_tens);
        close_test("ceiling scoring");

        $display("summary: %0d tests passed, %0d tests failed, %0d checks, %0d errors",
                 tests_passed, tests_failed, check_count, error_count);
        if (error_count == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    initial begin
        #(2 * WORST_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", 2 * WORST_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- filelist.f
hdl/slime_pkg.sv
hdl/slime_horizontal.sv
hdl/platform_detect.sv
hdl/jump_physics.sv
hdl/score_keeper.sv
hdl/slime_top.sv
bench/slime_tb.sv

//--- Bender.yml
package:
  name: slime

sources:
  - hdl/slime_pkg.sv
  - hdl/slime_horizontal.sv
  - hdl/platform_detect.sv
  - hdl/jump_physics.sv
  - hdl/score_keeper.sv
  - hdl/slime_top.sv
  - target: test
    files:
      - bench/slime_tb.sv
